// ==== logic/selfTest_defs.svh ====
`ifndef SELFTEST_DEFS_SVH
`define SELFTEST_DEFS_SVH

// --------------------------------------------------------------------------
// controller interface widths
// --------------------------------------------------------------------------

// address bus of the external sdram controller
`define ADDR_WIDTH 25
// one sdram word
`define DATA_WIDTH 16

// --------------------------------------------------------------------------
// test sequence
// --------------------------------------------------------------------------

// addresses 0 .. TEST_WORDS-1 are written and read back
`define TEST_WORDS 10
// used for both startup pauses
`define SETTLE_CYCLES 10
// gap between the last write and the first read
`define PAUSE_CYCLES 20
// expected word for address a is (a+1) * PATTERN_STEP
`define PATTERN_STEP 1000

// display
`define DIGITS 6
// wide enough for any index below TEST_WORDS
`define INDEX_WIDTH 4

`endif

// ==== logic/selfTestPkg.sv ====
`include "selfTest_defs.svh"

package selfTestPkg;

	// request towards the controller, all fields held while valid waits
	typedef struct packed {
		logic [`ADDR_WIDTH-1:0] address;
		logic [`DATA_WIDTH-1:0] writeData;
		logic                   isWriting;
		logic                   valid;
	} sdramRequest_t;

	// strobes and read data coming back from the controller
	typedef struct packed {
		logic [`DATA_WIDTH-1:0] readData;
		logic                   readValid;
		logic                   busy;
		logic                   commandTaken;
	} sdramResponse_t;

	typedef enum logic [1:0] {
		SETTLE_FIRST,
		WAIT_IDLE,
		SETTLE_SECOND,
		READY
	} startupState_t;

	typedef enum logic [2:0] {
		WRITE_ISSUE,
		WRITE_WAIT,
		PAUSE,
		READ_ISSUE,
		READ_WAIT,
		DONE
	} testState_t;

	// bit 0 is segment a, bit 6 is segment g, digit 0 is the rightmost
	typedef logic [`DIGITS-1:0][6:0] segmentDigits_t;

	// one read result per tested address
	typedef struct packed {
		logic [`INDEX_WIDTH-1:0] index;
		logic [`DATA_WIDTH-1:0]  data;
		logic                    strobe;
	} readback_t;

	// expected word for an address, (index+1) * PATTERN_STEP
	function automatic logic [`DATA_WIDTH-1:0] testPattern(input logic [`INDEX_WIDTH-1:0] index);
		logic [`DATA_WIDTH-1:0] product;
		product = (`DATA_WIDTH'(index) + 1'b1) * `DATA_WIDTH'(`PATTERN_STEP);
		return product;
	endfunction

	// decimal digit to active-high segments, blank for anything above 9
	function automatic logic [6:0] digitGlyph(input logic [3:0] digit);
		logic [6:0] glyph;
		case (digit)
			4'd0: glyph = 7'b0111111;
			4'd1: glyph = 7'b0000110;
			4'd2: glyph = 7'b1011011;
			4'd3: glyph = 7'b1001111;
			4'd4: glyph = 7'b1100110;
			4'd5: glyph = 7'b1101101;
			4'd6: glyph = 7'b1111101;
			4'd7: glyph = 7'b0000111;
			4'd8: glyph = 7'b1111111;
			4'd9: glyph = 7'b1101111;
			default: glyph = 7'b0000000;
		endcase
		return glyph;
	endfunction

endpackage

// ==== logic/powerUpWait.sv ====
`timescale 1ns/1ps
`include "selfTest_defs.svh"

module powerUpWait import selfTestPkg::*; (
	input  logic clock143Mhz,
	input  logic reset_n,
	input  logic busy,
	output logic ready
);

	localparam int SETTLE_WIDTH = $clog2(`SETTLE_CYCLES + 1);
	localparam logic [SETTLE_WIDTH-1:0] SETTLE_LAST = SETTLE_WIDTH'(`SETTLE_CYCLES - 1);

	startupState_t state;
	logic [SETTLE_WIDTH-1:0] settleCount;

	// test may start only after the full startup sequence
	assign ready = (state == READY);

	always_ff @(posedge clock143Mhz) begin
		if (!reset_n) begin
			state <= SETTLE_FIRST;
			settleCount <= '0;
		end else begin
			case (state)
				// give the controller time to raise busy
				SETTLE_FIRST: begin
					if (settleCount == SETTLE_LAST) begin
						settleCount <= '0;
						state <= WAIT_IDLE;
					end else begin
						settleCount <= settleCount + 1'b1;
					end
				end
				// controller is initialising the sdram, no limit on this wait
				WAIT_IDLE: begin
					if (!busy) begin
						settleCount <= '0;
						state <= SETTLE_SECOND;
					end
				end
				SETTLE_SECOND: begin
					if (settleCount == SETTLE_LAST) begin
						state <= READY;
					end else begin
						settleCount <= settleCount + 1'b1;
					end
				end
				// held until the next reset
				default: state <= READY;
			endcase
		end
	end

endmodule

// ==== logic/testSequencer.sv ====
`timescale 1ns/1ps
`include "selfTest_defs.svh"

module testSequencer import selfTestPkg::*; (
	input  logic           clock143Mhz,
	input  logic           reset_n,
	input  logic           ready,
	input  sdramResponse_t sdramResponse,
	output sdramRequest_t  sdramRequest,
	output readback_t      readback
);

	localparam logic [`INDEX_WIDTH-1:0] LAST_INDEX = `INDEX_WIDTH'(`TEST_WORDS - 1);
	localparam int PAUSE_WIDTH = $clog2(`PAUSE_CYCLES + 1);
	localparam logic [PAUSE_WIDTH-1:0] PAUSE_LAST = PAUSE_WIDTH'(`PAUSE_CYCLES - 1);

	testState_t state;
	logic [`INDEX_WIDTH-1:0] index;
	logic [PAUSE_WIDTH-1:0] pauseCount;

	// request fields
	logic requestValid;
	logic requestIsWriting;
	logic [`ADDR_WIDTH-1:0] requestAddress;
	logic [`DATA_WIDTH-1:0] requestWriteData;

	// read capture
	logic [`DATA_WIDTH-1:0] capturedData;
	logic readbackStrobe;
	logic [`INDEX_WIDTH-1:0] readbackIndex;
	logic [`DATA_WIDTH-1:0] readbackData;

	logic issueNow;
	logic commandDone;

	// a new command is loaded only while nothing is pending
	assign issueNow = !requestValid &&
		((state == WRITE_ISSUE && ready) || state == READ_ISSUE);
	// busy low after the command was taken ends it
	assign commandDone = !sdramResponse.busy;

	assign sdramRequest = '{address: requestAddress, writeData: requestWriteData,
		isWriting: requestIsWriting, valid: requestValid};
	assign readback = '{index: readbackIndex, data: readbackData, strobe: readbackStrobe};

	// --------------------------------------------------------------------------
	// sequence control
	// --------------------------------------------------------------------------

	always_ff @(posedge clock143Mhz) begin
		if (!reset_n) begin
			state <= WRITE_ISSUE;
			index <= '0;
			pauseCount <= '0;
			requestValid <= 1'b0;
			readbackStrobe <= 1'b0;
		end else begin
			readbackStrobe <= 1'b0;
			case (state)
				WRITE_ISSUE: begin
					if (requestValid && sdramResponse.commandTaken) begin
						requestValid <= 1'b0;
						state <= WRITE_WAIT;
					end else if (issueNow) begin
						requestValid <= 1'b1;
					end
				end
				WRITE_WAIT: begin
					if (commandDone) begin
						if (index == LAST_INDEX) begin
							index <= '0;
							pauseCount <= '0;
							state <= PAUSE;
						end else begin
							index <= index + 1'b1;
							state <= WRITE_ISSUE;
						end
					end
				end
				// idle gap before the read pass
				PAUSE: begin
					if (pauseCount == PAUSE_LAST) begin
						state <= READ_ISSUE;
					end else begin
						pauseCount <= pauseCount + 1'b1;
					end
				end
				READ_ISSUE: begin
					if (requestValid && sdramResponse.commandTaken) begin
						requestValid <= 1'b0;
						state <= READ_WAIT;
					end else if (issueNow) begin
						requestValid <= 1'b1;
					end
				end
				// one readback per address as the read finishes
				READ_WAIT: begin
					if (commandDone) begin
						readbackStrobe <= 1'b1;
						if (index == LAST_INDEX) begin
							state <= DONE;
						end else begin
							index <= index + 1'b1;
							state <= READ_ISSUE;
						end
					end
				end
				default: state <= DONE;
			endcase
		end
	end

	// --------------------------------------------------------------------------
	// request payload and read data
	// --------------------------------------------------------------------------

	always_ff @(posedge clock143Mhz) begin
		// loaded once, then stable until the command is taken
		if (issueNow) begin
			requestAddress <= `ADDR_WIDTH'(index);
			requestWriteData <= testPattern(index);
			requestIsWriting <= (state == WRITE_ISSUE);
		end
		// last readValid before busy falls wins
		if (state == READ_WAIT && sdramResponse.readValid) begin
			capturedData <= sdramResponse.readData;
		end
		// readValid only comes while busy is high, so the capture is complete here
		if (state == READ_WAIT && commandDone) begin
			readbackIndex <= index;
			readbackData <= capturedData;
		end
	end

endmodule

// ==== logic/resultChecker.sv ====
`timescale 1ns/1ps
`include "selfTest_defs.svh"

module resultChecker import selfTestPkg::*; (
	input  logic                    clock143Mhz,
	input  logic                    reset_n,
	input  readback_t               readback,
	input  logic [`INDEX_WIDTH-1:0] displayIndex,
	output logic                    compareError,
	output logic                    completedSuccess,
	output logic [`DATA_WIDTH-1:0]  displayWord
);

	localparam logic [`INDEX_WIDTH-1:0] LAST_INDEX = `INDEX_WIDTH'(`TEST_WORDS - 1);

	// one stored word per tested address
	logic [`DATA_WIDTH-1:0] storedWords [`TEST_WORDS];
	logic wordMatches;

	assign wordMatches = (readback.data == testPattern(readback.index));

	// display reads straight out of the store
	assign displayWord = storedWords[displayIndex];

	// --------------------------------------------------------------------------
	// store and verdict
	// --------------------------------------------------------------------------

	always_ff @(posedge clock143Mhz) begin
		if (!reset_n) begin
			// zeros so the display reads 000000 before the readback
			for (int i = 0; i < `TEST_WORDS; i++) begin
				storedWords[i] <= '0;
			end
			compareError <= 1'b0;
			completedSuccess <= 1'b0;
		end else if (readback.strobe) begin
			storedWords[readback.index] <= readback.data;
			// both flags are sticky
			if (!wordMatches) begin
				compareError <= 1'b1;
			end else if (readback.index == LAST_INDEX && !compareError) begin
				// last address read back with no earlier mismatch
				completedSuccess <= 1'b1;
			end
		end
	end

endmodule

// ==== logic/displayStepper.sv ====
`timescale 1ns/1ps
`include "selfTest_defs.svh"

module displayStepper (
	input  logic                    clock143Mhz,
	input  logic                    reset_n,
	input  logic                    stepButton,
	output logic [`INDEX_WIDTH-1:0] displayIndex
);

	localparam logic [`INDEX_WIDTH-1:0] LAST_INDEX = `INDEX_WIDTH'(`TEST_WORDS - 1);

	// button is asynchronous to the clock
	logic buttonMeta;
	logic buttonSync;
	logic buttonPrevious;
	logic stepPulse;

	// one pulse per press
	assign stepPulse = buttonSync && !buttonPrevious;

	always_ff @(posedge clock143Mhz) begin
		if (!reset_n) begin
			buttonMeta <= 1'b0;
			buttonSync <= 1'b0;
			buttonPrevious <= 1'b0;
			displayIndex <= '0;
		end else begin
			buttonMeta <= stepButton;
			buttonSync <= buttonMeta;
			buttonPrevious <= buttonSync;
			// wraps back to the first word
			if (stepPulse) begin
				displayIndex <= (displayIndex == LAST_INDEX) ? '0 : displayIndex + 1'b1;
			end
		end
	end

endmodule

// ==== logic/sevenSegmentDecoder.sv ====
`timescale 1ns/1ps
`include "selfTest_defs.svh"

module sevenSegmentDecoder import selfTestPkg::*; (
	input  logic                   clock143Mhz,
	input  logic                   reset_n,
	input  logic [`DATA_WIDTH-1:0] value,
	output segmentDigits_t         segments
);

	localparam int BCD_WIDTH = `DIGITS * 4;
	localparam int STEP_WIDTH = $clog2(`DATA_WIDTH);
	localparam logic [STEP_WIDTH-1:0] LAST_STEP = STEP_WIDTH'(`DATA_WIDTH - 1);

	// value of the last conversion started
	logic [`DATA_WIDTH-1:0] lastValue;
	// binary bits still to be shifted in
	logic [`DATA_WIDTH-1:0] shiftValue;
	logic [BCD_WIDTH-1:0] bcd;
	logic [BCD_WIDTH-1:0] adjustedBcd;
	logic [STEP_WIDTH-1:0] stepCount;
	logic converting;
	logic conversionDone;

	// add 3 to every digit of 5 or more before the next shift
	always_comb begin
		adjustedBcd = bcd;
		for (int d = 0; d < `DIGITS; d++) begin
			if (bcd[d*4 +: 4] >= 4'd5) begin
				adjustedBcd[d*4 +: 4] = bcd[d*4 +: 4] + 4'd3;
			end
		end
	end

	// --------------------------------------------------------------------------
	// conversion control and segment output
	// --------------------------------------------------------------------------

	always_ff @(posedge clock143Mhz) begin
		if (!reset_n) begin
			converting <= 1'b0;
			conversionDone <= 1'b0;
			stepCount <= '0;
			lastValue <= '0;
			// stored words reset to zero, so show zero on every digit
			for (int d = 0; d < `DIGITS; d++) begin
				segments[d] <= digitGlyph(4'd0);
			end
		end else begin
			conversionDone <= 1'b0;
			if (converting) begin
				stepCount <= stepCount + 1'b1;
				if (stepCount == LAST_STEP) begin
					converting <= 1'b0;
					conversionDone <= 1'b1;
				end
			end else if (value != lastValue) begin
				// a change during a conversion is picked up when it ends
				lastValue <= value;
				stepCount <= '0;
				converting <= 1'b1;
			end
			// leading zeros stay visible
			if (conversionDone) begin
				for (int d = 0; d < `DIGITS; d++) begin
					segments[d] <= digitGlyph(bcd[d*4 +: 4]);
				end
			end
		end
	end

	// shift register, one binary bit per cycle
	always_ff @(posedge clock143Mhz) begin
		if (converting) begin
			{bcd, shiftValue} <= {adjustedBcd, shiftValue} << 1;
		end else if (value != lastValue) begin
			shiftValue <= value;
			bcd <= '0;
		end
	end

endmodule

// ==== logic/sdramSelfTest.sv ====
`timescale 1ns/1ps
`include "selfTest_defs.svh"

module sdramSelfTest import selfTestPkg::*; (
	input  logic           clock143Mhz,
	input  logic           reset_n,
	input  logic           stepButton,
	input  sdramResponse_t sdramResponse,
	output sdramRequest_t  sdramRequest,
	output logic           compareError,
	output logic           completedSuccess,
	output segmentDigits_t segments
);

	// high once the controller has finished its own startup
	logic ready;
	// read results from the sequencer to the checker
	readback_t readback;
	// word currently chosen for the display
	logic [`INDEX_WIDTH-1:0] displayIndex;
	logic [`DATA_WIDTH-1:0] displayWord;

	// --------------------------------------------------------------------------
	// test path
	// --------------------------------------------------------------------------

	powerUpWait i_powerUpWait (
		.clock143Mhz (clock143Mhz),
		.reset_n     (reset_n),
		.busy        (sdramResponse.busy),
		.ready       (ready)
	);

	testSequencer i_testSequencer (
		.clock143Mhz   (clock143Mhz),
		.reset_n       (reset_n),
		.ready         (ready),
		.sdramResponse (sdramResponse),
		.sdramRequest  (sdramRequest),
		.readback      (readback)
	);

	resultChecker i_resultChecker (
		.clock143Mhz      (clock143Mhz),
		.reset_n          (reset_n),
		.readback         (readback),
		.displayIndex     (displayIndex),
		.compareError     (compareError),
		.completedSuccess (completedSuccess),
		.displayWord      (displayWord)
	);

	// --------------------------------------------------------------------------
	// display path
	// --------------------------------------------------------------------------

	displayStepper i_displayStepper (
		.clock143Mhz  (clock143Mhz),
		.reset_n      (reset_n),
		.stepButton   (stepButton),
		.displayIndex (displayIndex)
	);

	sevenSegmentDecoder i_sevenSegmentDecoder (
		.clock143Mhz (clock143Mhz),
		.reset_n     (reset_n),
		.value       (displayWord),
		.segments    (segments)
	);

endmodule

// ==== tests/controllerModel.sv ====
`timescale 1ns/1ps
`include "selfTest_defs.svh"

module controllerModel import selfTestPkg::*; (
	input  logic           clock143Mhz,
	input  logic           reset_n,
	input  sdramRequest_t  sdramRequest,
	input  logic [3:0]     takeDelay,
	input  logic           corruptEnable,
	input  logic [3:0]     corruptAddress,
	output sdramResponse_t sdramResponse,
	output logic [7:0]     readCount
);

	// busy time of the controller's own startup
	localparam logic [3:0] INIT_BUSY = 4'd8;
	// busy time of one command, counted from the take
	localparam logic [3:0] CMD_BUSY = 4'd3;
	// single bit flipped on a corrupted read
	localparam logic [`DATA_WIDTH-1:0] CORRUPT_MASK = `DATA_WIDTH'(16'h0010);

	// small memory, only the low address bits are decoded
	logic [`DATA_WIDTH-1:0] memory [16];
	// one bit per address that saw a write
	logic [15:0] writtenMask;
	// any write above the decoded range
	logic strayWrite;

	logic [3:0] busyLeft;
	logic [3:0] waitCount;
	logic activeRead;
	logic [3:0] activeAddress;
	logic busy;
	logic commandTaken;
	logic readValid;
	logic [`DATA_WIDTH-1:0] readData;

	assign sdramResponse = '{readData: readData, readValid: readValid, busy: busy,
		commandTaken: commandTaken};

	always_ff @(posedge clock143Mhz) begin
		if (!reset_n) begin
			for (int a = 0; a < 16; a++) begin
				memory[4'(a)] <= '0;
			end
			writtenMask <= '0;
			strayWrite <= 1'b0;
			// busy straight out of reset, like a real controller in init
			busy <= 1'b1;
			busyLeft <= INIT_BUSY;
			waitCount <= '0;
			activeRead <= 1'b0;
			activeAddress <= '0;
			commandTaken <= 1'b0;
			readValid <= 1'b0;
			readData <= '0;
			readCount <= '0;
		end else begin
			commandTaken <= 1'b0;
			readValid <= 1'b0;
			if (busyLeft != 4'd0) begin
				// read data comes back one cycle after the take
				if (activeRead && busyLeft == CMD_BUSY) begin
					readValid <= 1'b1;
					readData <= memory[activeAddress] ^
						((corruptEnable && activeAddress == corruptAddress) ? CORRUPT_MASK : '0);
					readCount <= readCount + 8'd1;
				end
				if (busyLeft == 4'd1) begin
					busy <= 1'b0;
					activeRead <= 1'b0;
				end
				busyLeft <= busyLeft - 4'd1;
			end else if (sdramRequest.valid) begin
				// hold the requester off for takeDelay cycles
				if (waitCount >= takeDelay) begin
					waitCount <= '0;
					commandTaken <= 1'b1;
					busy <= 1'b1;
					busyLeft <= CMD_BUSY;
					activeRead <= !sdramRequest.isWriting;
					activeAddress <= sdramRequest.address[3:0];
					if (sdramRequest.isWriting) begin
						memory[sdramRequest.address[3:0]] <= sdramRequest.writeData;
						if (sdramRequest.address[`ADDR_WIDTH-1:4] != '0) begin
							strayWrite <= 1'b1;
						end else begin
							writtenMask[sdramRequest.address[3:0]] <= 1'b1;
						end
					end
				end else begin
					waitCount <= waitCount + 4'd1;
				end
			end
		end
	end

endmodule

// ==== tests/tb_sdramSelfTest.sv ====
`timescale 1ns/1ps
`include "selfTest_defs.svh"

module tb_sdramSelfTest import selfTestPkg::*; ();

	// one whole self-test run, reset to verdict
	localparam int RUN_TIMEOUT = 2000;
	// step sync plus one decimal conversion, with margin
	localparam int SEGMENT_TIMEOUT = 100;
	// controller init plus margin
	localparam int INIT_TIMEOUT = 50;

	logic clock143Mhz;
	logic reset_n;
	logic stepButton;
	sdramRequest_t sdramRequest;
	sdramResponse_t sdramResponse;
	logic compareError;
	logic completedSuccess;
	segmentDigits_t segments;

	// controller model knobs
	logic [3:0] takeDelay;
	logic corruptEnable;
	logic [3:0] corruptAddress;
	logic [7:0] readCount;
	logic randomDelays;

	// request hold monitor
	logic holdMonitorOn;
	sdramRequest_t lastRequest;
	logic lastTaken;

	integer seed;
	int errorCount;
	int testErrors;
	int testsRun;
	int testsFailed;

	sdramSelfTest i_sdramSelfTest (
		.clock143Mhz      (clock143Mhz),
		.reset_n          (reset_n),
		.stepButton       (stepButton),
		.sdramResponse    (sdramResponse),
		.sdramRequest     (sdramRequest),
		.compareError     (compareError),
		.completedSuccess (completedSuccess),
		.segments         (segments)
	);

	controllerModel i_controllerModel (
		.clock143Mhz    (clock143Mhz),
		.reset_n        (reset_n),
		.sdramRequest   (sdramRequest),
		.takeDelay      (takeDelay),
		.corruptEnable  (corruptEnable),
		.corruptAddress (corruptAddress),
		.sdramResponse  (sdramResponse),
		.readCount      (readCount)
	);

	initial begin
		clock143Mhz = 1'b0;
		forever #5 clock143Mhz = ~clock143Mhz;
	end

	// --------------------------------------------------------------------------
	// expected values
	// --------------------------------------------------------------------------

	// word written to address a is (a+1) * 1000
	function automatic logic [`DATA_WIDTH-1:0] expectedWord(input int index);
		return `DATA_WIDTH'((index + 1) * `PATTERN_STEP);
	endfunction

	// segment a in bit 0, g in bit 6
	function automatic logic [6:0] glyphOf(input int digit);
		case (digit)
			0: return 7'h3f;
			1: return 7'h06;
			2: return 7'h5b;
			3: return 7'h4f;
			4: return 7'h66;
			5: return 7'h6d;
			6: return 7'h7d;
			7: return 7'h07;
			8: return 7'h7f;
			9: return 7'h6f;
			default: return 7'h00;
		endcase
	endfunction

	// all digits with leading zeros, digit 0 rightmost
	function automatic logic [`DIGITS*7-1:0] expectedSegments(input logic [`DATA_WIDTH-1:0] value);
		logic [`DIGITS*7-1:0] pattern;
		int rest;
		rest = int'(value);
		for (int d = 0; d < `DIGITS; d++) begin
			pattern[d*7 +: 7] = glyphOf(rest % 10);
			rest = rest / 10;
		end
		return pattern;
	endfunction

	// --------------------------------------------------------------------------
	// helpers
	// --------------------------------------------------------------------------

	// inputs change and outputs are read 1 ns after the edge
	task automatic advanceCycle();
		@(posedge clock143Mhz);
		#1;
	endtask

	task automatic reportMismatch(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		errorCount++;
		testErrors++;
		$display("Fail %s: expected %h, got %h", name, expected, actual);
	endtask

	task automatic reportProblem(input string text);
		errorCount++;
		testErrors++;
		$display("%s", text);
	endtask

	task automatic applyReset();
		reset_n = 1'b0;
		repeat (2) advanceCycle();
		reset_n = 1'b1;
	endtask

	task automatic beginTest();
		testErrors = 0;
	endtask

	task automatic endTest(input string name);
		testsRun++;
		if (testErrors == 0) begin
			$display("%s: ok", name);
		end else begin
			testsFailed++;
			$display("%s: %0d errors", name, testErrors);
		end
	endtask

	// either verdict flag ends the wait
	task automatic waitForVerdict();
		int cycles;
		cycles = 0;
		while (!completedSuccess && !compareError && cycles < RUN_TIMEOUT) begin
			advanceCycle();
			cycles++;
		end
		if (!completedSuccess && !compareError) begin
			reportProblem("timeout waiting for the self-test verdict");
		end
	endtask

	// all reads answered and the last one finished
	task automatic waitForReadPass();
		int cycles;
		cycles = 0;
		while (!(readCount == 8'(`TEST_WORDS) && !sdramResponse.busy) &&
			cycles < RUN_TIMEOUT) begin
			advanceCycle();
			cycles++;
		end
		if (cycles >= RUN_TIMEOUT) begin
			reportProblem("timeout waiting for the read pass to finish");
		end
		// readback strobe, then the verdict register
		repeat (3) advanceCycle();
	endtask

	task automatic waitForSegments(input logic [`DIGITS*7-1:0] expected);
		int cycles;
		cycles = 0;
		while (segments !== expected && cycles < SEGMENT_TIMEOUT) begin
			advanceCycle();
			cycles++;
		end
		if (segments !== expected) begin
			reportMismatch("segments", 64'(expected), 64'(segments));
		end
	endtask

	// long enough for the two-flop sync on both edges
	task automatic pressStep();
		stepButton = 1'b1;
		repeat (3) advanceCycle();
		stepButton = 1'b0;
		repeat (3) advanceCycle();
	endtask

	// --------------------------------------------------------------------------
	// directed tests
	// --------------------------------------------------------------------------

	task automatic testResetState();
		int cycles;
		beginTest();
		applyReset();
		if (sdramRequest.valid !== 1'b0) begin
			reportMismatch("sdramRequest.valid", 64'd0, 64'(sdramRequest.valid));
		end
		if (compareError !== 1'b0) begin
			reportMismatch("compareError", 64'd0, 64'(compareError));
		end
		if (completedSuccess !== 1'b0) begin
			reportMismatch("completedSuccess", 64'd0, 64'(completedSuccess));
		end
		if (segments !== expectedSegments('0)) begin
			reportMismatch("segments", 64'(expectedSegments('0)), 64'(segments));
		end
		// nothing may be requested during controller init
		cycles = 0;
		while (sdramResponse.busy && cycles < INIT_TIMEOUT) begin
			if (sdramRequest.valid) begin
				reportProblem("request raised while the controller was still busy");
			end
			advanceCycle();
			cycles++;
		end
		if (sdramResponse.busy) begin
			reportProblem("timeout waiting for the controller to leave init");
		end
		endTest("reset state");
	endtask

	task automatic testFullPass();
		beginTest();
		takeDelay = 4'd0;
		applyReset();
		waitForVerdict();
		if (completedSuccess !== 1'b1) begin
			reportMismatch("completedSuccess", 64'd1, 64'(completedSuccess));
		end
		if (compareError !== 1'b0) begin
			reportMismatch("compareError", 64'd0, 64'(compareError));
		end
		for (int a = 0; a < `TEST_WORDS; a++) begin
			if (i_controllerModel.memory[4'(a)] !== expectedWord(a)) begin
				reportMismatch($sformatf("memory[%0d]", a), 64'(expectedWord(a)),
					64'(i_controllerModel.memory[4'(a)]));
			end
		end
		if (i_controllerModel.writtenMask !== 16'((1 << `TEST_WORDS) - 1)) begin
			reportMismatch("writtenMask", 64'((1 << `TEST_WORDS) - 1),
				64'(i_controllerModel.writtenMask));
		end
		if (i_controllerModel.strayWrite) begin
			reportProblem("a write went to an address outside the tested range");
		end
		endTest("full pass");
	endtask

	task automatic testBackPressure();
		beginTest();
		takeDelay = 4'($random(seed) & 32'hf);
		randomDelays = 1'b1;
		holdMonitorOn = 1'b1;
		applyReset();
		waitForVerdict();
		if (completedSuccess !== 1'b1) begin
			reportMismatch("completedSuccess", 64'd1, 64'(completedSuccess));
		end
		if (compareError !== 1'b0) begin
			reportMismatch("compareError", 64'd0, 64'(compareError));
		end
		randomDelays = 1'b0;
		holdMonitorOn = 1'b0;
		takeDelay = 4'd0;
		endTest("back-pressure");
	endtask

	task automatic testCorruption();
		beginTest();
		corruptEnable = 1'b1;
		corruptAddress = 4'd3;
		applyReset();
		waitForVerdict();
		waitForReadPass();
		if (compareError !== 1'b1) begin
			reportMismatch("compareError", 64'd1, 64'(compareError));
		end
		if (completedSuccess !== 1'b0) begin
			reportMismatch("completedSuccess", 64'd0, 64'(completedSuccess));
		end
		corruptEnable = 1'b0;
		endTest("corruption");
	endtask

	task automatic testDisplayStepping();
		beginTest();
		applyReset();
		waitForVerdict();
		if (completedSuccess !== 1'b1) begin
			reportMismatch("completedSuccess", 64'd1, 64'(completedSuccess));
		end
		// last position wraps back to index 0
		for (int i = 0; i <= `TEST_WORDS; i++) begin
			if (i > 0) begin
				pressStep();
			end
			waitForSegments(expectedSegments(expectedWord(i % `TEST_WORDS)));
		end
		endTest("display stepping");
	endtask

	// --------------------------------------------------------------------------
	// stimulus side processes
	// --------------------------------------------------------------------------

	// new take delay after every accepted command
	always @(posedge clock143Mhz) begin
		#1;
		if (randomDelays && sdramResponse.commandTaken) begin
			takeDelay = 4'($random(seed) & 32'hf);
		end
	end

	// a waiting request must not change until it is taken
	always @(negedge clock143Mhz) begin
		if (holdMonitorOn && reset_n && lastRequest.valid && !lastTaken) begin
			if (sdramRequest !== lastRequest) begin
				reportMismatch("sdramRequest", 64'(lastRequest), 64'(sdramRequest));
			end
		end
		lastRequest = sdramRequest;
		lastTaken = sdramResponse.commandTaken;
	end

	initial begin
		#1_000_000;
		$display("simulation stopped by the global timeout");
		$display("*** TEST FAILED ***");
		$finish;
	end

	initial begin
		seed = 32'haacc0a59;
		reset_n = 1'b0;
		stepButton = 1'b0;
		takeDelay = 4'd0;
		corruptEnable = 1'b0;
		corruptAddress = 4'd0;
		randomDelays = 1'b0;
		holdMonitorOn = 1'b0;
		lastRequest = '0;
		lastTaken = 1'b0;
		errorCount = 0;
		testErrors = 0;
		testsRun = 0;
		testsFailed = 0;

		testResetState();
		testFullPass();
		testBackPressure();
		testCorruption();
		testDisplayStepping();

		$display("tests run %0d, tests failed %0d, check errors %0d",
			testsRun, testsFailed, errorCount);
		if (errorCount == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

// ==== src.f ====
+incdir+logic
logic/selfTestPkg.sv
logic/powerUpWait.sv
logic/testSequencer.sv
logic/resultChecker.sv
logic/displayStepper.sv
logic/sevenSegmentDecoder.sv
logic/sdramSelfTest.sv
tests/controllerModel.sv
tests/tb_sdramSelfTest.sv

// ==== Makefile ====
# Verilator build and run of the SDRAM self-test testbench

TOP := tb_sdramSelfTest

.PHONY: compile run clean

compile:
	verilator --binary --timing -f src.f --top-module $(TOP) -Mdir obj_dir -o sim

run: compile
	./obj_dir/sim | tee sim.log
	@if grep -qF '*** TEST FAILED ***' sim.log; then exit 1; fi
	@grep -qF '*** TEST PASSED ***' sim.log

clean:
	rm -rf obj_dir sim.log
